// ==== include/dcache_defines.svh ====
////////////////////////////////////////////////////////////////////////////
// widths, line count and write buffer depth for the data cache
////////////////////////////////////////////////////////////////////////////

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// core side
`define DCACHE_ADDR_W 32
`define DCACHE_DATA_W 32
`define DCACHE_BE_W 4

// direct-mapped, one word per line
`define DCACHE_LINES 16
`define DCACHE_IDX_W 4
// address minus index and the two byte offset bits
`define DCACHE_TAG_W 26

// store buffer
`define DCACHE_WBUF_DEPTH 4
`define DCACHE_WBUF_PTR_W 2

`endif

// ==== verilog/dcache_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared packed struct types for the data cache
// load and store requests, memory commands and the cache write ports
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

package dcache_pkg;

  typedef struct packed {
    logic                      valid;
    logic [`DCACHE_ADDR_W-1:0] addr;
  } load_req_t;

  // also the write buffer entry
  typedef struct packed {
    logic [`DCACHE_ADDR_W-1:0] addr;
    logic [`DCACHE_DATA_W-1:0] data;
    logic [`DCACHE_BE_W-1:0]   be;
  } store_req_t;

  typedef struct packed {
    logic                      we;
    logic [`DCACHE_ADDR_W-1:0] addr;
    logic [`DCACHE_DATA_W-1:0] data;
    logic [`DCACHE_BE_W-1:0]   be;
  } mem_req_t;

  // line fill from the miss unit
  typedef struct packed {
    logic                      valid;
    logic [`DCACHE_IDX_W-1:0]  idx;
    logic [`DCACHE_TAG_W-1:0]  tag;
    logic [`DCACHE_DATA_W-1:0] data;
  } refill_t;

  // store hit update
  typedef struct packed {
    logic                      valid;
    logic [`DCACHE_IDX_W-1:0]  idx;
    logic [`DCACHE_DATA_W-1:0] data;
    logic [`DCACHE_BE_W-1:0]   be;
  } word_wr_t;

endpackage

// ==== verilog/dcache_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// direct-mapped tag, valid and data arrays
// load and store hit lookup, refill and byte-enabled word writes
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module dcache_mem (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      enable_i,
  input  logic [`DCACHE_ADDR_W-1:0] ld_addr_i,
  input  logic [`DCACHE_ADDR_W-1:0] st_addr_i,
  input  dcache_pkg::refill_t       refill_i,
  input  dcache_pkg::word_wr_t      word_wr_i,
  input  logic                      flush_inv_i,
  output logic                      ld_hit_o,
  output logic [`DCACHE_DATA_W-1:0] ld_data_o,
  output logic                      st_hit_o
);

  logic [`DCACHE_LINES-1:0]  valid_q;
  logic [`DCACHE_TAG_W-1:0]  tag_q  [`DCACHE_LINES];
  logic [`DCACHE_DATA_W-1:0] data_q [`DCACHE_LINES];
  logic [`DCACHE_IDX_W-1:0]  ld_idx;
  logic [`DCACHE_IDX_W-1:0]  st_idx;
  logic [`DCACHE_TAG_W-1:0]  ld_tag;
  logic [`DCACHE_TAG_W-1:0]  st_tag;
  logic                      refill_we;

  assign ld_idx = ld_addr_i[`DCACHE_IDX_W+1:2];
  assign ld_tag = ld_addr_i[`DCACHE_ADDR_W-1:`DCACHE_IDX_W+2];
  assign st_idx = st_addr_i[`DCACHE_IDX_W+1:2];
  assign st_tag = st_addr_i[`DCACHE_ADDR_W-1:`DCACHE_IDX_W+2];

  // disabled cache never hits and never fills
  assign ld_hit_o  = enable_i & valid_q[ld_idx] & (tag_q[ld_idx] == ld_tag);
  assign st_hit_o  = enable_i & valid_q[st_idx] & (tag_q[st_idx] == st_tag);
  assign ld_data_o = data_q[ld_idx];

  assign refill_we = refill_i.valid & enable_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (flush_inv_i) begin
      valid_q <= '0;
    end else if (refill_we) begin
      valid_q[refill_i.idx] <= 1'b1;
    end
  end

  // refill wins over a store update
  always_ff @(posedge clk_i) begin
    if (refill_we) begin
      tag_q[refill_i.idx]  <= refill_i.tag;
      data_q[refill_i.idx] <= refill_i.data;
    end else if (word_wr_i.valid) begin
      for (int b = 0; b < `DCACHE_BE_W; b++) begin
        if (word_wr_i.be[b]) begin
          data_q[word_wr_i.idx][8*b +: 8] <= word_wr_i.data[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/dcache_load_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// load port FSM
// grants loads, answers hits one cycle later, hands misses on
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module dcache_load_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  dcache_pkg::load_req_t     ld_req_i,
  input  logic                      ld_hit_i,
  input  logic [`DCACHE_DATA_W-1:0] ld_data_i,
  input  logic                      miss_done_i,
  input  logic [`DCACHE_DATA_W-1:0] miss_data_i,
  output logic                      ld_gnt_o,
  output logic                      ld_rvalid_o,
  output logic [`DCACHE_DATA_W-1:0] ld_rdata_o,
  output logic                      miss_o,
  output logic                      miss_req_o,
  output logic [`DCACHE_ADDR_W-1:0] miss_addr_o,
  output logic                      ld_busy_o
);

  typedef enum logic [1:0] {LD_IDLE, LD_RESP, LD_MISS} ld_state_e;

  ld_state_e                 state_q;
  ld_state_e                 state_d;
  logic [`DCACHE_ADDR_W-1:0] addr_q;
  logic [`DCACHE_DATA_W-1:0] data_q;
  logic                      grant;

  // one load in flight, so only grant from idle
  assign grant       = (state_q == LD_IDLE) & ld_req_i.valid;
  assign ld_gnt_o    = grant;
  assign miss_o      = grant & ~ld_hit_i;
  assign ld_rvalid_o = (state_q == LD_RESP);
  assign ld_rdata_o  = data_q;
  assign miss_req_o  = (state_q == LD_MISS);
  assign miss_addr_o = addr_q;
  assign ld_busy_o   = (state_q != LD_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (grant) begin
          state_d = ld_hit_i ? LD_RESP : LD_MISS;
        end
      end
      LD_RESP: state_d = LD_IDLE;
      LD_MISS: begin
        if (miss_done_i) begin
          state_d = LD_RESP;
        end
      end
      default: state_d = LD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // hit data at grant, refill word at miss completion
  always_ff @(posedge clk_i) begin
    if (grant) begin
      addr_q <= ld_req_i.addr;
      data_q <= ld_data_i;
    end else if (miss_done_i) begin
      data_q <= miss_data_i;
    end
  end

endmodule

// ==== verilog/dcache_wbuffer.sv ====
////////////////////////////////////////////////////////////////////////////
// store FIFO in front of the memory port
// issues the byte-enabled cache update on a store hit
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module dcache_wbuffer (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      st_valid_i,
  input  dcache_pkg::store_req_t    st_req_i,
  input  logic                      st_hit_i,
  input  logic                      rd_open_i,
  input  logic                      wbuf_pop_i,
  output logic                      st_gnt_o,
  output logic [`DCACHE_ADDR_W-1:0] st_addr_o,
  output dcache_pkg::word_wr_t      word_wr_o,
  output logic                      wbuf_valid_o,
  output dcache_pkg::store_req_t    wbuf_head_o,
  output logic                      empty_o
);

  dcache_pkg::store_req_t         fifo_q [`DCACHE_WBUF_DEPTH];
  logic [`DCACHE_WBUF_PTR_W-1:0]  wr_ptr_q;
  logic [`DCACHE_WBUF_PTR_W-1:0]  rd_ptr_q;
  logic [`DCACHE_WBUF_PTR_W:0]    count_q;
  logic                           full;

  assign full    = (count_q == (`DCACHE_WBUF_PTR_W+1)'(`DCACHE_WBUF_DEPTH));
  assign empty_o = (count_q == '0);

  // no new store while a refill read is open
  assign st_gnt_o  = st_valid_i & ~full & ~rd_open_i;
  assign st_addr_o = st_req_i.addr;

  // store hit update, written at the grant edge
  assign word_wr_o.valid = st_gnt_o & st_hit_i;
  assign word_wr_o.idx   = st_req_i.addr[`DCACHE_IDX_W+1:2];
  assign word_wr_o.data  = st_req_i.data;
  assign word_wr_o.be    = st_req_i.be;

  assign wbuf_valid_o = ~empty_o;
  assign wbuf_head_o  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (st_gnt_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (wbuf_pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({st_gnt_o, wbuf_pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_gnt_o) begin
      fifo_q[wr_ptr_q] <= st_req_i;
    end
  end

endmodule

// ==== verilog/dcache_missunit.sv ====
////////////////////////////////////////////////////////////////////////////
// memory port FSM
// drains the write buffer, serves load misses and sequences the flush
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module dcache_missunit (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  input  logic                      miss_req_i,
  input  logic [`DCACHE_ADDR_W-1:0] miss_addr_i,
  input  logic                      ld_busy_i,
  input  logic                      wbuf_valid_i,
  input  dcache_pkg::store_req_t    wbuf_head_i,
  input  logic                      wbuf_empty_i,
  input  logic                      mem_ack_i,
  input  logic                      mem_rvalid_i,
  input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i,
  output logic                      flush_ack_o,
  output logic                      busy_o,
  output logic                      miss_done_o,
  output logic [`DCACHE_DATA_W-1:0] miss_data_o,
  output dcache_pkg::refill_t       refill_o,
  output logic                      flush_inv_o,
  output logic                      wbuf_pop_o,
  output logic                      rd_open_o,
  output logic                      mem_req_o,
  output dcache_pkg::mem_req_t      mem_o
);

  typedef enum logic [2:0] {MU_IDLE, MU_WRITE, MU_RD_REQ, MU_RD_WAIT, MU_FLUSH} mu_state_e;

  mu_state_e state_q;
  mu_state_e state_d;
  logic      go_read;
  logic      go_flush;

  // reads and flushes only start with the buffer drained
  assign go_read  = (state_q == MU_IDLE) & wbuf_empty_i & miss_req_i;
  assign go_flush = (state_q == MU_IDLE) & wbuf_empty_i & ~ld_busy_i & flush_i;

  // also high in the launch cycle so no store slips in behind the read
  assign rd_open_o = go_read | (state_q == MU_RD_REQ) | (state_q == MU_RD_WAIT);

  assign mem_req_o   = (state_q == MU_WRITE) | (state_q == MU_RD_REQ);
  assign wbuf_pop_o  = (state_q == MU_WRITE) & mem_ack_i;
  assign miss_done_o = (state_q == MU_RD_WAIT) & mem_rvalid_i;
  assign miss_data_o = mem_rdata_i;
  assign flush_ack_o = (state_q == MU_FLUSH);
  assign flush_inv_o = (state_q == MU_FLUSH);
  assign busy_o      = ~wbuf_empty_i | ld_busy_i | (state_q != MU_IDLE);

  // fill the missed line as the word returns
  assign refill_o.valid = miss_done_o;
  assign refill_o.idx   = miss_addr_i[`DCACHE_IDX_W+1:2];
  assign refill_o.tag   = miss_addr_i[`DCACHE_ADDR_W-1:`DCACHE_IDX_W+2];
  assign refill_o.data  = mem_rdata_i;

  always_comb begin
    mem_o = '0;
    if (state_q == MU_WRITE) begin
      mem_o.we   = 1'b1;
      mem_o.addr = wbuf_head_i.addr;
      mem_o.data = wbuf_head_i.data;
      mem_o.be   = wbuf_head_i.be;
    end else if (state_q == MU_RD_REQ) begin
      mem_o.addr = miss_addr_i;
      mem_o.be   = '1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      MU_IDLE: begin
        // buffered stores go first
        if (wbuf_valid_i) begin
          state_d = MU_WRITE;
        end else if (go_read) begin
          state_d = MU_RD_REQ;
        end else if (go_flush) begin
          state_d = MU_FLUSH;
        end
      end
      MU_WRITE:   if (mem_ack_i) state_d = MU_IDLE;
      MU_RD_REQ:  if (mem_ack_i) state_d = MU_RD_WAIT;
      MU_RD_WAIT: if (mem_rvalid_i) state_d = MU_IDLE;
      MU_FLUSH:   state_d = MU_IDLE;
      default:    state_d = MU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== verilog/dcache_top.sv ====
////////////////////////////////////////////////////////////////////////////
// write-through data cache top level
// connects the arrays, load controller, write buffer and miss unit
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module dcache_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      enable_i,
  input  logic                      flush_i,
  output logic                      flush_ack_o,
  output logic                      busy_o,
  output logic                      miss_o,
  output logic                      wbuffer_empty_o,
  input  dcache_pkg::load_req_t     ld_req_i,
  output logic                      ld_gnt_o,
  output logic                      ld_rvalid_o,
  output logic [`DCACHE_DATA_W-1:0] ld_rdata_o,
  input  logic                      st_valid_i,
  input  dcache_pkg::store_req_t    st_req_i,
  output logic                      st_gnt_o,
  output logic                      mem_req_o,
  output dcache_pkg::mem_req_t      mem_o,
  input  logic                      mem_ack_i,
  input  logic                      mem_rvalid_i,
  input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i
);

  // lookups
  logic                      ld_hit;
  logic [`DCACHE_DATA_W-1:0] ld_data;
  logic                      st_hit;
  logic [`DCACHE_ADDR_W-1:0] st_addr;

  // cache writes
  dcache_pkg::word_wr_t      word_wr;
  dcache_pkg::refill_t       refill;
  logic                      flush_inv;

  // load controller <-> miss unit
  logic                      miss_req;
  logic [`DCACHE_ADDR_W-1:0] miss_addr;
  logic                      miss_done;
  logic [`DCACHE_DATA_W-1:0] miss_data;
  logic                      ld_busy;

  // write buffer <-> miss unit
  logic                      wbuf_valid;
  dcache_pkg::store_req_t    wbuf_head;
  logic                      wbuf_pop;
  logic                      rd_open;

  ////////////////////////////////////////////////////////////////////////////
  // tag, valid and data arrays
  ////////////////////////////////////////////////////////////////////////////

  dcache_mem i_dcache_mem (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .ld_addr_i   (ld_req_i.addr),
    .st_addr_i   (st_addr),
    .refill_i    (refill),
    .word_wr_i   (word_wr),
    .flush_inv_i (flush_inv),
    .ld_hit_o    (ld_hit),
    .ld_data_o   (ld_data),
    .st_hit_o    (st_hit)
  );

  dcache_load_ctrl i_dcache_load_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ld_req_i    (ld_req_i),
    .ld_hit_i    (ld_hit),
    .ld_data_i   (ld_data),
    .miss_done_i (miss_done),
    .miss_data_i (miss_data),
    .ld_gnt_o    (ld_gnt_o),
    .ld_rvalid_o (ld_rvalid_o),
    .ld_rdata_o  (ld_rdata_o),
    .miss_o      (miss_o),
    .miss_req_o  (miss_req),
    .miss_addr_o (miss_addr),
    .ld_busy_o   (ld_busy)
  );

  // store side, producer into the buffer
  dcache_wbuffer i_dcache_wbuffer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .st_valid_i   (st_valid_i),
    .st_req_i     (st_req_i),
    .st_hit_i     (st_hit),
    .rd_open_i    (rd_open),
    .wbuf_pop_i   (wbuf_pop),
    .st_gnt_o     (st_gnt_o),
    .st_addr_o    (st_addr),
    .word_wr_o    (word_wr),
    .wbuf_valid_o (wbuf_valid),
    .wbuf_head_o  (wbuf_head),
    .empty_o      (wbuffer_empty_o)
  );

  // memory port owner, consumer of the buffer
  dcache_missunit i_dcache_missunit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .miss_req_i   (miss_req),
    .miss_addr_i  (miss_addr),
    .ld_busy_i    (ld_busy),
    .wbuf_valid_i (wbuf_valid),
    .wbuf_head_i  (wbuf_head),
    .wbuf_empty_i (wbuffer_empty_o),
    .mem_ack_i    (mem_ack_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .flush_ack_o  (flush_ack_o),
    .busy_o       (busy_o),
    .miss_done_o  (miss_done),
    .miss_data_o  (miss_data),
    .refill_o     (refill),
    .flush_inv_o  (flush_inv),
    .wbuf_pop_o   (wbuf_pop),
    .rd_open_o    (rd_open),
    .mem_req_o    (mem_req_o),
    .mem_o        (mem_o)
  );

endmodule

// ==== verification/tb_dcache_mem_model.sv ====
////////////////////////////////////////////////////////////////////////////
// behavioral memory for the data cache testbench
// 256 words, read and write counters, write log, held acknowledges
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module tb_dcache_mem_model (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      hold_ack_i,
  input  logic                      mem_req_i,
  input  dcache_pkg::mem_req_t      mem_i,
  output logic                      mem_ack_o,
  output logic                      mem_rvalid_o,
  output logic [`DCACHE_DATA_W-1:0] mem_rdata_o,
  output int                        rd_count_o,
  output int                        wr_count_o
);

  logic [`DCACHE_DATA_W-1:0] mem [256];
  dcache_pkg::mem_req_t      wr_log [64];
  logic [7:0]                widx;

  // every bit of the byte address reaches the fill word
  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
  endfunction

  assign widx      = mem_i.addr[9:2];
  assign mem_ack_o = mem_req_i & ~hold_ack_i;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 256; i++) begin
        mem[i[7:0]] <= fill_word({22'd0, i[7:0], 2'b00});
      end
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
      rd_count_o   <= 0;
      wr_count_o   <= 0;
    end else begin
      mem_rvalid_o <= 1'b0;
      if (mem_ack_o && mem_i.we) begin
        for (int b = 0; b < `DCACHE_BE_W; b++) begin
          if (mem_i.be[b]) begin
            mem[widx][8*b +: 8] <= mem_i.data[8*b +: 8];
          end
        end
        if (wr_count_o < 64) begin
          wr_log[wr_count_o[5:0]] <= mem_i;
        end
        wr_count_o <= wr_count_o + 1;
      end else if (mem_ack_o) begin
        // read data comes back one cycle after the acknowledge
        mem_rvalid_o <= 1'b1;
        mem_rdata_o  <= mem[widx];
        rd_count_o   <= rd_count_o + 1;
      end
    end
  end

endmodule

// ==== verification/tb_dcache.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the write-through data cache
// clock, reset, LFSR stimulus and directed tests with their checks
////////////////////////////////////////////////////////////////////////////

`include "dcache_defines.svh"

module tb_dcache;

  localparam int TIMEOUT = 200;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      enable;
  logic                      flush;
  logic                      flush_ack;
  logic                      busy;
  logic                      miss;
  logic                      wbuf_empty;
  dcache_pkg::load_req_t     ld_req;
  logic                      ld_gnt;
  logic                      ld_rvalid;
  logic [`DCACHE_DATA_W-1:0] ld_rdata;
  logic                      st_valid;
  dcache_pkg::store_req_t    st_req;
  logic                      st_gnt;
  logic                      mem_req;
  dcache_pkg::mem_req_t      mem_cmd;
  logic                      mem_ack;
  logic                      mem_rvalid;
  logic [`DCACHE_DATA_W-1:0] mem_rdata;
  logic                      hold_ack;
  int                        rd_count;
  int                        wr_count;

  logic [15:0]               lfsr_q;
  int                        mismatch_cnt;
  int                        timeout_cnt;

  // result of the last load
  logic [31:0]               ld_data;
  logic                      ld_missed;
  int                        ld_latency;

  dcache_top dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .enable_i        (enable),
    .flush_i         (flush),
    .flush_ack_o     (flush_ack),
    .busy_o          (busy),
    .miss_o          (miss),
    .wbuffer_empty_o (wbuf_empty),
    .ld_req_i        (ld_req),
    .ld_gnt_o        (ld_gnt),
    .ld_rvalid_o     (ld_rvalid),
    .ld_rdata_o      (ld_rdata),
    .st_valid_i      (st_valid),
    .st_req_i        (st_req),
    .st_gnt_o        (st_gnt),
    .mem_req_o       (mem_req),
    .mem_o           (mem_cmd),
    .mem_ack_i       (mem_ack),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata)
  );

  tb_dcache_mem_model mem_model_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .hold_ack_i   (hold_ack),
    .mem_req_i    (mem_req),
    .mem_i        (mem_cmd),
    .mem_ack_o    (mem_ack),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .rd_count_o   (rd_count),
    .wr_count_o   (wr_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and reference helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois form with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // word aligned address inside the 256 word model
  task automatic rand_addr(output logic [31:0] a);
    logic [31:0] r;
    take_bits(8, r);
    a = {22'd0, r[7:0], 2'b00};
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        m[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return m;
  endfunction

  function automatic logic [31:0] model_word(logic [31:0] a);
    return mem_model_i.mem[a[9:2]];
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_int(input string what, input int got, input int exp);
    if (got != exp) begin
      mismatch_cnt++;
      $display("mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("timeout at time %0t while waiting for %s", $time, what);
    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    $display("Simulation FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_word(input logic [31:0] addr);
    int   cycles;
    logic done;
    @(posedge clk_i);
    #2;
    ld_req.valid = 1'b1;
    ld_req.addr  = addr;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge clk_i);
      done      = ld_gnt;
      ld_missed = miss;
      cycles++;
      if (!done && cycles > TIMEOUT) begin
        report_timeout("load grant");
      end
    end
    @(posedge clk_i);
    #2;
    ld_req.valid = 1'b0;
    // count cycles from the grant edge to the data pulse
    done       = 1'b0;
    ld_latency = 0;
    while (!done) begin
      @(negedge clk_i);
      ld_latency++;
      done = ld_rvalid;
      if (!done && ld_latency > TIMEOUT) begin
        report_timeout("load data");
      end
    end
    ld_data = ld_rdata;
  endtask

  task automatic store_begin(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
    @(posedge clk_i);
    #2;
    st_valid     = 1'b1;
    st_req.addr  = addr;
    st_req.data  = data;
    st_req.be    = be;
  endtask

  task automatic store_wait_grant();
    int   cycles;
    logic done;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge clk_i);
      done = st_gnt;
      cycles++;
      if (!done && cycles > TIMEOUT) begin
        report_timeout("store grant");
      end
    end
    @(posedge clk_i);
    #2;
    st_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (busy) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout("cache idle");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_miss_then_hit(input logic [31:0] a);
    int          rd_before;
    logic [31:0] exp;
    exp       = model_word(a);
    rd_before = rd_count;
    load_word(a);
    check_word("first load data", ld_data, exp);
    check_int("miss_o on first load", int'(ld_missed), 1);
    check_int("reads after first load", rd_count, rd_before + 1);
    load_word(a);
    check_word("repeat load data", ld_data, exp);
    check_int("miss_o on repeat load", int'(ld_missed), 0);
    check_int("reads after repeat load", rd_count, rd_before + 1);
    check_int("hit latency", ld_latency, 1);
  endtask

  task automatic test_store_merge(input logic [31:0] a);
    int          rd_before;
    logic [31:0] d;
    logic [31:0] exp;
    take_bits(32, d);
    exp       = merge_bytes(model_word(a), d, 4'b0101);
    rd_before = rd_count;
    store_begin(a, d, 4'b0101);
    store_wait_grant();
    wait_idle();
    check_word("memory after partial store", model_word(a), exp);
    load_word(a);
    check_word("load after partial store", ld_data, exp);
    check_int("miss_o after store hit", int'(ld_missed), 0);
    check_int("reads after store hit", rd_count, rd_before);
  endtask

  task automatic test_backpressure();
    dcache_pkg::store_req_t sent [`DCACHE_WBUF_DEPTH+1];
    dcache_pkg::mem_req_t   entry;
    int                     wr_before;
    int                     stray;
    logic [31:0]            r;
    for (int k = 0; k <= `DCACHE_WBUF_DEPTH; k++) begin
      rand_addr(r);
      sent[k].addr = r;
      take_bits(32, r);
      sent[k].data = r;
      sent[k].be   = 4'hf;
    end
    wr_before = wr_count;
    @(posedge clk_i);
    #2;
    hold_ack = 1'b1;
    for (int k = 0; k < `DCACHE_WBUF_DEPTH; k++) begin
      store_begin(sent[k].addr, sent[k].data, sent[k].be);
      store_wait_grant();
    end
    // extra store must stall on the full buffer
    store_begin(sent[`DCACHE_WBUF_DEPTH].addr, sent[`DCACHE_WBUF_DEPTH].data, 4'hf);
    stray = 0;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_i);
      if (st_gnt) begin
        stray++;
      end
    end
    check_int("grants while buffer full", stray, 0);
    check_int("busy_o with writes held", int'(busy), 1);
    @(posedge clk_i);
    #2;
    hold_ack = 1'b0;
    store_wait_grant();
    wait_idle();
    check_int("writes after release", wr_count - wr_before, `DCACHE_WBUF_DEPTH + 1);
    for (int k = 0; k <= `DCACHE_WBUF_DEPTH; k++) begin
      entry = mem_model_i.wr_log[6'(wr_before + k)];
      check_word("write order address", entry.addr, sent[k].addr);
      check_word("write order data", entry.data, sent[k].data);
    end
    check_int("wbuffer_empty_o after drain", int'(wbuf_empty), 1);
  endtask

  task automatic test_flush(input logic [31:0] a);
    logic [31:0] s0;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] exp;
    int          wr_before;
    int          rd_before;
    int          cycles;
    int          acks;
    rand_addr(s0);
    take_bits(32, d0);
    take_bits(32, d1);
    wr_before = wr_count;
    store_begin(s0, d0, 4'hf);
    store_wait_grant();
    store_begin(s0 ^ 32'h100, d1, 4'hf);
    store_wait_grant();
    @(posedge clk_i);
    #2;
    flush  = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!flush_ack) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout("flush acknowledge");
      end
    end
    check_int("writes done at flush ack", wr_count - wr_before, 2);
    check_int("buffer empty at flush ack", int'(wbuf_empty), 1);
    @(posedge clk_i);
    #2;
    flush = 1'b0;
    acks  = 0;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk_i);
      if (flush_ack) begin
        acks++;
      end
    end
    check_int("extra flush acks", acks, 0);
    check_word("first store before flush", model_word(s0), d0);
    check_word("second store before flush", model_word(s0 ^ 32'h100), d1);
    // the cached line must be fetched again
    exp       = model_word(a);
    rd_before = rd_count;
    load_word(a);
    check_word("load after flush", ld_data, exp);
    check_int("miss_o after flush", int'(ld_missed), 1);
    check_int("reads after flush", rd_count, rd_before + 1);
  endtask

  task automatic test_disabled(input logic [31:0] a);
    int          rd_before;
    logic [31:0] d;
    logic [31:0] exp;
    @(posedge clk_i);
    #2;
    enable = 1'b0;
    for (int k = 0; k < 2; k++) begin
      exp       = model_word(a);
      rd_before = rd_count;
      load_word(a);
      check_word("disabled load data", ld_data, exp);
      check_int("miss_o while disabled", int'(ld_missed), 1);
      check_int("reads while disabled", rd_count, rd_before + 1);
    end
    take_bits(32, d);
    store_begin(a, d, 4'hf);
    store_wait_grant();
    wait_idle();
    check_word("store while disabled", model_word(a), d);
    rd_before = rd_count;
    load_word(a);
    check_word("load after disabled store", ld_data, d);
    check_int("reads after disabled store", rd_count, rd_before + 1);
  endtask

  initial begin
    logic [31:0] a;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    lfsr_q       = 16'd60893;
    arst_n_i     = 1'b0;
    enable       = 1'b1;
    flush        = 1'b0;
    ld_req       = '0;
    st_valid     = 1'b0;
    st_req       = '0;
    hold_ack     = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    rand_addr(a);
    test_miss_then_hit(a);
    test_store_merge(a);
    test_backpressure();
    test_flush(a);
    test_disabled(a);

    repeat (2) @(posedge clk_i);
    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_mem.sv
verilog/dcache_load_ctrl.sv
verilog/dcache_wbuffer.sv
verilog/dcache_missunit.sv
verilog/dcache_top.sv
verification/tb_dcache_mem_model.sv
verification/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_dcache -Mdir obj_dir
./obj_dir/Vtb_dcache > sim.log
cat sim.log
if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi
